/* source/axis_fifo_pkg.sv */
// Shared sizes for the frame FIFO; every RTL module imports this package.
package axis_fifo_pkg;

    // ########################################################################
    // Stream field widths.
    // ########################################################################

    localparam int data_width = 8;
    localparam int id_width = 4;
    localparam int dest_width = 4;

    // ########################################################################
    // Storage and pointer sizes.
    // ########################################################################

    // number of words the frame RAM holds.
    localparam int fifo_depth = 64;
    localparam int addr_width = 6;

    // one extra wrap bit tells a full FIFO apart from an empty one.
    localparam int ptr_width = addr_width + 1;

    // a stored word packs data, id, dest and last, most significant first.
    localparam int word_width = data_width + id_width + dest_width + 1;

    // the depth reports must reach fifo_depth itself.
    localparam int depth_width = 7;

endpackage

/* source/frame_ram_arbiter.sv */
// Single-port frame RAM shared by the writer and reader; the writer has fixed priority.
module frame_ram_arbiter
    import axis_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // writer port, always served.
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [word_width-1:0] wr_word,

    // reader port, served only in cycles without a write.
    input  logic                  rd_req,
    input  logic [addr_width-1:0] rd_addr,
    output logic                  rd_grant,
    output logic [word_width-1:0] rd_word,
    output logic                  rd_word_valid
);

    logic [word_width-1:0] mem [fifo_depth];

    // the single address port goes to the reader only when the writer is idle.
    assign rd_grant = rd_req & ~wr_en;

    // ########################################################################
    // Storage access.
    // ########################################################################

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_grant) begin
            rd_word <= mem[rd_addr];
        end
    end

    // the strobe marks the cycle in which rd_word holds the granted word.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_word_valid <= 1'b0;
        end else begin
            rd_word_valid <= rd_grant;
        end
    end

endmodule

/* source/axis_frame_writer.sv */
// Frame writer of the FIFO: accepts input beats, writes them to RAM and commits or drops frames.
module axis_frame_writer
    import axis_fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // input stream.
    input  logic [data_width-1:0]  in_tdata,
    input  logic [id_width-1:0]    in_tid,
    input  logic [dest_width-1:0]  in_tdest,
    input  logic                   in_tlast,
    input  logic                   in_tuser,
    input  logic                   in_tvalid,
    output logic                   in_tready,

    // RAM write port.
    output logic                   wr_en,
    output logic [addr_width-1:0]  wr_addr,
    output logic [word_width-1:0]  wr_word,

    // pointers shared with the reader.
    input  logic [ptr_width-1:0]   read_ptr,
    output logic [ptr_width-1:0]   commit_ptr,

    // status.
    output logic [depth_width-1:0] status_depth,
    output logic [depth_width-1:0] status_depth_commit,
    output logic                   status_overflow,
    output logic                   status_bad_frame,
    output logic                   status_good_frame
);

    // tentative pointer, one past the last word of the frame being written.
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] fill;
    logic [ptr_width-1:0] fill_commit;
    logic                 accept;
    logic                 full;
    logic                 dropping;

    assign accept = in_tvalid & in_tready;

    // both fills are taken modulo the pointer range before any comparison.
    assign fill = wr_ptr - read_ptr;
    assign fill_commit = commit_ptr - read_ptr;
    assign full = (fill == ptr_width'(fifo_depth));

    // ########################################################################
    // RAM write port.
    // ########################################################################

    // a beat of a frame that is being dropped never reaches the RAM.
    assign wr_en = accept & ~dropping & ~full;
    assign wr_addr = wr_ptr[addr_width-1:0];
    assign wr_word = {in_tdata, in_tid, in_tdest, in_tlast};

    // ########################################################################
    // Frame commit, rollback and drop.
    // ########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            in_tready <= 1'b0;
            wr_ptr <= '0;
            commit_ptr <= '0;
            dropping <= 1'b0;
            status_overflow <= 1'b0;
            status_bad_frame <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            // the writer always wins the RAM, so input is never held back.
            in_tready <= 1'b1;
            status_overflow <= 1'b0;
            status_bad_frame <= 1'b0;
            status_good_frame <= 1'b0;

            if (accept) begin
                if (dropping || full) begin
                    // out of space. Throw the frame away up to its last beat.
                    wr_ptr <= commit_ptr;
                    dropping <= ~in_tlast;
                    status_overflow <= in_tlast;
                end else if (in_tlast) begin
                    if (in_tuser) begin
                        wr_ptr <= commit_ptr;
                        status_bad_frame <= 1'b1;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                        status_good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // ########################################################################
    // Depth reports.
    // ########################################################################

    // words already fetched by the reader are no longer counted here.
    always_ff @(posedge clk) begin
        if (reset) begin
            status_depth <= '0;
            status_depth_commit <= '0;
        end else begin
            status_depth <= fill;
            status_depth_commit <= fill_commit;
        end
    end

endmodule

/* source/axis_frame_reader.sv */
// Frame reader of the FIFO: fetches committed words, buffers two of them and drives the output.
module axis_frame_reader
    import axis_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // committed write pointer from the writer.
    input  logic [ptr_width-1:0]  commit_ptr,

    // RAM read port.
    output logic                  rd_req,
    output logic [addr_width-1:0] rd_addr,
    input  logic                  rd_grant,
    input  logic [word_width-1:0] rd_word,
    input  logic                  rd_word_valid,
    output logic [ptr_width-1:0]  read_ptr,

    // output stream.
    output logic [data_width-1:0] out_tdata,
    output logic [id_width-1:0]   out_tid,
    output logic [dest_width-1:0] out_tdest,
    output logic                  out_tlast,
    output logic                  out_tvalid,
    input  logic                  out_tready,

    // pause handshake.
    input  logic                  pause_req,
    output logic                  pause_ack
);

    // entry 0 is the head of the buffer.
    logic [word_width-1:0] buf_word [2];
    logic [1:0]            buf_count;
    logic [1:0]            outstanding;
    logic                  pop;
    logic                  between_frames;
    logic                  next_between;

    // ########################################################################
    // Read scheduling.
    // ########################################################################

    // a word returning from the RAM this cycle still counts against the buffer.
    assign outstanding = buf_count + {1'b0, rd_word_valid};
    assign rd_req = (outstanding < 2'd2) && (read_ptr != commit_ptr);
    assign rd_addr = read_ptr[addr_width-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            read_ptr <= '0;
        end else if (rd_grant) begin
            read_ptr <= read_ptr + 1'b1;
        end
    end

    // ########################################################################
    // Output buffer.
    // ########################################################################

    assign out_tvalid = (buf_count != 2'd0) && !pause_ack;
    assign pop = out_tvalid & out_tready;
    assign {out_tdata, out_tid, out_tdest, out_tlast} = buf_word[0];

    always_ff @(posedge clk) begin
        if (rd_word_valid && !pop) begin
            buf_word[buf_count[0]] <= rd_word;
        end else if (pop && !rd_word_valid) begin
            buf_word[0] <= buf_word[1];
        end else if (pop && rd_word_valid) begin
            // only the head is occupied here, so the new word replaces it.
            buf_word[0] <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_count <= '0;
        end else if (rd_word_valid && !pop) begin
            buf_count <= buf_count + 1'b1;
        end else if (pop && !rd_word_valid) begin
            buf_count <= buf_count - 1'b1;
        end
    end

    // ########################################################################
    // Frame-boundary pause.
    // ########################################################################

    // the position after this edge, so a pause never splits a frame.
    assign next_between = pop ? out_tlast : between_frames;

    always_ff @(posedge clk) begin
        if (reset) begin
            between_frames <= 1'b1;
            pause_ack <= 1'b0;
        end else begin
            between_frames <= next_between;
            pause_ack <= pause_req && (pause_ack || next_between);
        end
    end

endmodule

/* source/axis_fifo_top.sv */
// Top level of the frame FIFO; connects the writer, the reader and the shared frame RAM.
module axis_fifo_top
    import axis_fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // input stream.
    input  logic [data_width-1:0]  in_tdata,
    input  logic [id_width-1:0]    in_tid,
    input  logic [dest_width-1:0]  in_tdest,
    input  logic                   in_tlast,
    input  logic                   in_tuser,
    input  logic                   in_tvalid,
    output logic                   in_tready,

    // output stream.
    output logic [data_width-1:0]  out_tdata,
    output logic [id_width-1:0]    out_tid,
    output logic [dest_width-1:0]  out_tdest,
    output logic                   out_tlast,
    output logic                   out_tvalid,
    input  logic                   out_tready,

    // pause and status.
    input  logic                   pause_req,
    output logic                   pause_ack,
    output logic [depth_width-1:0] status_depth,
    output logic [depth_width-1:0] status_depth_commit,
    output logic                   status_overflow,
    output logic                   status_bad_frame,
    output logic                   status_good_frame
);

    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [word_width-1:0] wr_word;
    logic                  rd_req;
    logic [addr_width-1:0] rd_addr;
    logic                  rd_grant;
    logic [word_width-1:0] rd_word;
    logic                  rd_word_valid;
    logic [ptr_width-1:0]  commit_ptr;
    logic [ptr_width-1:0]  read_ptr;

    axis_frame_writer writer_i (
        .clk, .reset,
        .in_tdata, .in_tid, .in_tdest, .in_tlast, .in_tuser, .in_tvalid, .in_tready,
        .wr_en, .wr_addr, .wr_word,
        .read_ptr, .commit_ptr,
        .status_depth, .status_depth_commit,
        .status_overflow, .status_bad_frame, .status_good_frame
    );

    axis_frame_reader reader_i (
        .clk, .reset,
        .commit_ptr,
        .rd_req, .rd_addr, .rd_grant, .rd_word, .rd_word_valid, .read_ptr,
        .out_tdata, .out_tid, .out_tdest, .out_tlast, .out_tvalid, .out_tready,
        .pause_req, .pause_ack
    );

    frame_ram_arbiter ram_i (
        .clk, .reset,
        .wr_en, .wr_addr, .wr_word,
        .rd_req, .rd_addr, .rd_grant, .rd_word, .rd_word_valid
    );

endmodule

/* tb/axis_fifo_tb.sv */
// Testbench for the frame FIFO; compiled with the RTL from the file list and run as the top level.
module axis_fifo_tb
    import axis_fifo_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_frames = 48;
    localparam int max_len = fifo_depth + 16;
    localparam int pause_len = 12;
    localparam int margin = 10;
    localparam logic [31:0] lfsr_seed = 32'h91a5;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic [data_width-1:0]  in_tdata;
    logic [id_width-1:0]    in_tid;
    logic [dest_width-1:0]  in_tdest;
    logic                   in_tlast;
    logic                   in_tuser;
    logic                   in_tvalid;
    logic                   in_tready;
    logic [data_width-1:0]  out_tdata;
    logic [id_width-1:0]    out_tid;
    logic [dest_width-1:0]  out_tdest;
    logic                   out_tlast;
    logic                   out_tvalid;
    logic                   out_tready;
    logic                   pause_req;
    logic                   pause_ack;
    logic [depth_width-1:0] status_depth;
    logic [depth_width-1:0] status_depth_commit;
    logic                   status_overflow;
    logic                   status_bad_frame;
    logic                   status_good_frame;

    // words of good frames in commit order; exp_head points at the next one due out.
    logic [word_width-1:0]  exp_q[$];
    int                     exp_head = 0;
    int                     n_good = 0;
    int                     n_bad = 0;
    int                     n_over = 0;
    int                     good_seen = 0;
    int                     bad_seen = 0;
    int                     over_seen = 0;
    int                     cycles = 0;
    logic                   stim_done = 1'b0;
    logic                   mid_frame = 1'b0;
    logic                   reset_prev = 1'b1;
    logic [word_width-1:0]  got;
    logic [31:0]            stim_lfsr = lfsr_seed;
    logic [31:0]            ready_lfsr = lfsr_seed;
    logic [31:0]            pause_lfsr = lfsr_seed;

    axis_fifo_top dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ########################################################################
    // Helpers.
    // ########################################################################

    // one LFSR step per bit, taps 32, 22, 2 and 1.
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic report_error(input string msg);
        $display(">>> FAIL");
        $display("Error at %0.1f ns: %s", $realtime, msg);
        $fatal(1, "stopping at the first error");
    endtask

    task automatic send_frame(input int len, input logic bad, input logic oversize);
        logic [id_width-1:0]   id;
        logic [dest_width-1:0] dest;
        logic [data_width-1:0] data;
        logic                  last;
        logic [word_width-1:0] words[$];
        id = id_width'(take_bits(stim_lfsr, id_width));
        dest = dest_width'(take_bits(stim_lfsr, dest_width));
        for (int i = 0; i < len; i++) begin
            data = data_width'(take_bits(stim_lfsr, data_width));
            last = (i == len - 1);
            if (take_bits(stim_lfsr, 2) == 32'd0) begin
                repeat (int'(take_bits(stim_lfsr, 2)) + 1) @(posedge clk);
                #0.5;
            end
            in_tdata = data;
            in_tid = id;
            in_tdest = dest;
            in_tlast = last;
            in_tuser = bad && last;
            in_tvalid = 1'b1;
            @(negedge clk);
            while (!in_tready) @(negedge clk);
            @(posedge clk);
            #0.5;
            in_tvalid = 1'b0;
            words.push_back({data, id, dest, last});
        end
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        if (oversize) begin
            n_over++;
        end else if (bad) begin
            n_bad++;
        end else begin
            foreach (words[k]) begin
                exp_q.push_back(words[k]);
            end
            n_good++;
        end
    endtask

    // ########################################################################
    // Stimulus.
    // ########################################################################

    initial begin
        int   len;
        logic bad;
        logic oversize;
        in_tdata = '0;
        in_tid = '0;
        in_tdest = '0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        in_tvalid = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        reset = 1'b0;
        for (int f = 0; f < num_frames; f++) begin
            oversize = (f % 12 == 5);
            bad = 1'b0;
            if (oversize) begin
                len = fifo_depth + 1 + int'(take_bits(stim_lfsr, 4));
            end else begin
                len = int'(take_bits(stim_lfsr, 5)) + 1;
                bad = (take_bits(stim_lfsr, 2) == 32'd0);
                // a normal frame starts only when the model has room for all of it.
                while (fifo_depth - (exp_q.size() - exp_head) < len) begin
                    @(posedge clk);
                    #0.5;
                end
            end
            send_frame(len, bad, oversize);
        end
        stim_done = 1'b1;
        while (exp_head != exp_q.size()) begin
            @(posedge clk);
            #0.5;
        end
        repeat (4) @(negedge clk);
        assert (status_depth == '0 && status_depth_commit == '0)
            else report_error($sformatf("depths %0d and %0d after draining, expected 0",
                                        status_depth, status_depth_commit));
        assert (good_seen == n_good)
            else report_error($sformatf("%0d good frame pulses, expected %0d", good_seen, n_good));
        assert (bad_seen == n_bad)
            else report_error($sformatf("%0d bad frame pulses, expected %0d", bad_seen, n_bad));
        assert (over_seen == n_over)
            else report_error($sformatf("%0d overflow pulses, expected %0d", over_seen, n_over));
        $display(">>> PASS");
        $finish;
    end

    initial begin
        out_tready = 1'b0;
        wait (!reset);
        forever begin
            out_tready = (take_bits(ready_lfsr, 2) != 32'd0);
            @(posedge clk);
            #0.5;
        end
    end

    initial begin
        pause_req = 1'b0;
        wait (!reset);
        while (!stim_done) begin
            repeat (int'(take_bits(pause_lfsr, 6)) + 8) @(posedge clk);
            #0.5;
            pause_req = 1'b1;
            repeat (pause_len) @(posedge clk);
            #0.5;
            pause_req = 1'b0;
        end
    end

    initial begin
        repeat (num_frames * max_len * margin) @(posedge clk);
        $display(">>> FAIL");
        $display("timeout: the run did not finish within %0d cycles", num_frames * max_len * margin);
        $fatal(1, "watchdog expired");
    end

    // ########################################################################
    // Checks.
    // ########################################################################

    // inputs only change just after a rising edge, so the falling edge sees stable values.
    always @(negedge clk) begin
        if (reset) begin
            if (cycles > 0) begin
                assert (!in_tready && !out_tvalid && !pause_ack && !status_overflow
                        && !status_bad_frame && !status_good_frame)
                    else report_error("an output was active during reset");
            end
        end else begin
            if (!reset_prev) begin
                assert (in_tready) else report_error("in_tready was low after reset");
            end
            if (out_tvalid && out_tready) begin
                got = {out_tdata, out_tid, out_tdest, out_tlast};
                assert (exp_head < exp_q.size())
                    else report_error("an output beat appeared that no good frame accounts for");
                assert (got == exp_q[exp_head])
                    else report_error($sformatf("output word %h, expected %h",
                                                got, exp_q[exp_head]));
                mid_frame = !out_tlast;
                exp_head++;
            end
            assert (!(pause_ack && mid_frame)) else report_error("pause_ack rose inside a frame");
            if (status_good_frame) good_seen++;
            if (status_bad_frame) bad_seen++;
            if (status_overflow) over_seen++;
        end
        reset_prev = reset;
    end

    assert property (@(posedge clk) disable iff (reset)
        out_tvalid && !out_tready |=> $stable({out_tdata, out_tid, out_tdest, out_tlast})
            && (out_tvalid || pause_ack))
        else report_error("the output beat changed or vanished while stalled");

    assert property (@(posedge clk) disable iff (reset) pause_ack |-> !out_tvalid)
        else report_error("out_tvalid was high while paused");

    assert property (@(posedge clk) disable iff (reset) !pause_req |=> !pause_ack)
        else report_error("pause_ack stayed high after pause_req fell");

    // mid_frame already includes the beat that leaves at this edge.
    assert property (@(posedge clk) disable iff (reset) pause_req && !mid_frame |=> pause_ack)
        else report_error("pause_ack did not rise for a request between frames");

    assert property (@(posedge clk) disable iff (reset)
        (status_depth_commit <= status_depth) && (status_depth <= depth_width'(fifo_depth)))
        else report_error("status depths out of range");

endmodule

/* src.f */
source/axis_fifo_pkg.sv
source/frame_ram_arbiter.sv
source/axis_frame_writer.sv
source/axis_frame_reader.sv
source/axis_fifo_top.sv
tb/axis_fifo_tb.sv

/* Makefile */
# Verilator flow for the frame FIFO testbench.
TOP := axis_fifo_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@grep -q "^>>> PASS$$" sim.log || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log
